/* bench/coreTrace.txt */
# I <instruction word>  program in fetch order from address 0
# S <address> <data>    expected stores in program order
I 00500093
I FFD00113
I 002081B3
I 40118233
I 001272B3
I 0022E333
I 003343B3
I 10403023
I 10503423
I 10603823
I 10703C23
I 10003403
I 001404B3
I 12903023
I 00108663
I 1E103823
I 1E203C23
I 00109463
I 00C0056F
I 1E103423
I 1E103023
I 12A03423
I 12303823
I 0000006F
S 100 FFFFFFFFFFFFFFFD
S 108 0000000000000005
S 110 FFFFFFFFFFFFFFFD
S 118 FFFFFFFFFFFFFFFF
S 120 0000000000000002
S 128 000000000000004C
S 130 0000000000000002

/* vlog.f */
design/corePkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/hazardControl.sv
design/core.sv
bench/coreTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# build and run from the project root
verilator --binary --assert --timing --top-module coreTb -f vlog.f -o coreSim > build.log 2>&1 \
    && ./obj_dir/coreSim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

/* bench/coreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module coreTb;

    logic clk;
    logic rstN;
    logic ifStall;
    logic memStall;
    logic stallsOn;
    logic [63:0] pc;
    logic [31:0] inst;
    logic [63:0] address;
    logic weMem;
    logic [63:0] wdataMem;
    logic reMem;
    logic [63:0] rdataMem;

    logic [31:0] imem [0:255];
    logic [63:0] dmem [0:63];
    logic [63:0] expAddr [$];
    logic [63:0] expData [$];
    logic [63:0] gotAddr [$];
    logic [63:0] gotData [$];
    int errors;
    int testsRun;
    int testsFailed;
    int mark;

    core #(.resetVector(64'h0)) DUT (
        .clk(clk), .rstN(rstN), .pc(pc), .inst(inst), .address(address), .weMem(weMem),
        .wdataMem(wdataMem), .reMem(reMem), .rdataMem(rdataMem), .ifStall(ifStall),
        .memStall(memStall)
    );

    assign inst = imem[pc[9:2]];  // both memories answer in the same cycle
    assign rdataMem = reMem ? dmem[address[8:3]] : 64'h0;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // **************************************************
    // memory model and stall source
    // **************************************************
    always @(posedge clk) begin
        if (rstN && weMem && !memStall) begin
            dmem[address[8:3]] <= wdataMem;
            gotAddr.push_back(address);
            gotData.push_back(wdataMem);
        end
    end

    always @(posedge clk) begin
        #1;
        ifStall <= stallsOn && ($urandom % 4 == 0);
        memStall <= stallsOn && ($urandom % 4 == 0);
    end

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic loadTrace();
        int fd;
        int code;
        int n;
        string line;
        logic [63:0] a;
        logic [63:0] d;
        logic [31:0] w;
        n = 0;
        fd = $fopen("bench/coreTrace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file bench/coreTrace.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) break;
            if ($sscanf(line, "I %h", w) == 1) begin
                imem[n] = w;
                n++;
            end else if ($sscanf(line, "S %h %h", a, d) == 2) begin
                expAddr.push_back(a);
                expData.push_back(d);
            end
        end
        $fclose(fd);
        if (n == 0 || expAddr.size() == 0) begin
            $display("the trace file holds no program words or no expected stores");
            errors++;
        end
    endtask

    task automatic runProgram(input logic withStalls);
        int cycles;
        stallsOn = 1'b0;
        gotAddr.delete();
        gotData.delete();
        for (int i = 0; i < 64; i++) dmem[i] <= 64'h0;
        @(posedge clk);
        #1 rstN = 1'b0;
        repeat (8) begin
            @(posedge clk);
            #1;
            checkValue("weMem", 64'h0, {63'h0, weMem});
            checkValue("reMem", 64'h0, {63'h0, reMem});
            checkValue("pc", 64'h0, pc);
        end
        rstN = 1'b1;
        @(posedge clk);
        stallsOn = withStalls;
        #1;
        checkValue("weMem", 64'h0, {63'h0, weMem});
        checkValue("reMem", 64'h0, {63'h0, reMem});
        checkValue("pc", 64'h4, pc);  // first fetch came from the reset vector
        cycles = 0;
        while (gotAddr.size() < expAddr.size() && cycles < 600) begin
            @(posedge clk);
            cycles++;
        end
        if (gotAddr.size() < expAddr.size()) begin
            $display("timeout: only %0d of %0d stores seen", gotAddr.size(), expAddr.size());
            errors++;
        end
        repeat (40) @(posedge clk);  // extra stores would show up here
        stallsOn = 1'b0;
    endtask

    task automatic compareStores(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            if (i >= gotAddr.size()) begin
                $display("store %0d never happened", i);
                errors++;
            end else begin
                checkValue($sformatf("address[%0d]", i), expAddr[i], gotAddr[i]);
                checkValue($sformatf("wdataMem[%0d]", i), expData[i], gotData[i]);
            end
        end
    endtask

    task automatic reportTest(input string name);
        testsRun++;
        if (errors != mark) testsFailed++;
        $display("%-22s %s", name, (errors != mark) ? "failed" : "passed");
        mark = errors;
    endtask

    initial begin
        rstN = 1'b0;
        ifStall = 1'b0;
        memStall = 1'b0;
        stallsOn = 1'b0;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        mark = 0;
        void'($urandom(32'h2c6c_1a54));
        for (int i = 0; i < 256; i++) imem[i] = 32'h0;
        loadTrace();
        reportTest("trace load");

        runProgram(1'b0);
        reportTest("reset");
        compareStores(0, 3);
        reportTest("arithmetic");
        compareStores(4, 4);
        reportTest("load then use");
        compareStores(5, expAddr.size() - 1);
        checkValue("store count", 64'(expAddr.size()), 64'(gotAddr.size()));
        reportTest("control flow");

        runProgram(1'b1);
        compareStores(0, expAddr.size() - 1);
        checkValue("store count", 64'(expAddr.size()), 64'(gotAddr.size()));
        reportTest("random stalls");

        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/core.sv */
`timescale 1ns/1ps
`default_nettype none

module core import corePkg::*; #(
    parameter logic [dataWidth-1:0] resetVector = '0
) (
    input  wire                   clk,
    input  wire                   rstN,
    output logic [dataWidth-1:0]  pc,
    input  wire  [instWidth-1:0]  inst,
    output logic [dataWidth-1:0]  address,
    output logic                  weMem,
    output logic [dataWidth-1:0]  wdataMem,
    output logic                  reMem,
    input  wire  [dataWidth-1:0]  rdataMem,
    input  wire                   ifStall,
    input  wire                   memStall
);

    logic [dataWidth-1:0] idPc;
    logic [instWidth-1:0] idInst;
    logic idValid;
    idExT idEx;
    exMemT exMem;
    memWbT wb;
    logic [dataWidth-1:0] loadData;
    logic redirect;
    logic [dataWidth-1:0] redirectPc;
    logic pcStall;
    logic ifIdStall;
    logic ifIdFlush;
    logic idExStall;
    logic idExFlush;
    logic exMemStall;
    logic memWbFlush;

    fetchStage #(.resetVector(resetVector)) fetch (
        .clk(clk), .rstN(rstN), .pcStall(pcStall), .ifIdStall(ifIdStall),
        .ifIdFlush(ifIdFlush), .redirect(redirect), .redirectPc(redirectPc),
        .inst(inst), .pc(pc), .idPc(idPc), .idInst(idInst), .idValid(idValid)
    );

    decodeStage decode (
        .clk(clk), .rstN(rstN), .idPc(idPc), .idInst(idInst), .idValid(idValid),
        .idExStall(idExStall), .idExFlush(idExFlush), .wb(wb), .idEx(idEx)
    );

    executeStage execute (
        .clk(clk), .rstN(rstN), .idEx(idEx), .memStage(exMem), .loadData(loadData),
        .wb(wb), .exMemStall(exMemStall), .exMem(exMem), .redirect(redirect),
        .redirectPc(redirectPc)
    );

    memoryStage memory (
        .clk(clk), .rstN(rstN), .exMem(exMem), .memWbFlush(memWbFlush),
        .rdataMem(rdataMem), .address(address), .wdataMem(wdataMem), .weMem(weMem),
        .reMem(reMem), .loadData(loadData), .wb(wb)
    );

    hazardControl hazard (
        .ifStall(ifStall), .memStall(memStall), .redirect(redirect),
        .pcStall(pcStall), .ifIdStall(ifIdStall), .ifIdFlush(ifIdFlush),
        .idExStall(idExStall), .idExFlush(idExFlush), .exMemStall(exMemStall),
        .memWbFlush(memWbFlush)
    );

endmodule

`default_nettype wire

/* design/hazardControl.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardControl (
    input  wire   ifStall,
    input  wire   memStall,
    input  wire   redirect,
    output logic  pcStall,
    output logic  ifIdStall,
    output logic  ifIdFlush,
    output logic  idExStall,
    output logic  idExFlush,
    output logic  exMemStall,
    output logic  memWbFlush
);

    // a pending redirect still moves pc while fetch is stalled
    assign pcStall = memStall | (ifStall & ~redirect);
    assign ifIdStall = memStall;
    assign ifIdFlush = ~memStall & (ifStall | redirect);
    assign idExStall = memStall;
    assign idExFlush = ~memStall & redirect;  // branch is held in execute during the stall
    assign exMemStall = memStall;
    assign memWbFlush = memStall;

endmodule

`default_nettype wire

/* design/memoryStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryStage import corePkg::*; (
    input  wire                   clk,
    input  wire                   rstN,
    input  wire exMemT            exMem,
    input  wire                   memWbFlush,
    input  wire  [dataWidth-1:0]  rdataMem,
    output logic [dataWidth-1:0]  address,
    output logic [dataWidth-1:0]  wdataMem,
    output logic                  weMem,
    output logic                  reMem,
    output logic [dataWidth-1:0]  loadData,
    output memWbT                 wb
);

    memWbT wbNext;

    assign address = exMem.aluResult;
    assign wdataMem = exMem.storeData;
    assign weMem = exMem.valid & exMem.weMem;  // held high through a memory stall
    assign reMem = exMem.valid & exMem.reMem;
    assign loadData = rdataMem;

    always_comb begin
        wbNext.valid = exMem.valid;
        wbNext.weReg = exMem.valid & exMem.weReg;
        wbNext.rd = exMem.rd;
        case (exMem.wbSel)
            wbMem: wbNext.data = rdataMem;
            wbPcPlus4: wbNext.data = exMem.pc + dataWidth'(4);
            default: wbNext.data = exMem.aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN || memWbFlush) begin
            wb.valid <= 1'b0;
            wb.weReg <= 1'b0;
        end else begin
            wb <= wbNext;
        end
    end

    assert property (@(posedge clk) !(weMem && reMem));

endmodule

`default_nettype wire

/* design/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage import corePkg::*; (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire idExT            idEx,
    input  wire exMemT           memStage,
    input  wire [dataWidth-1:0]  loadData,
    input  wire memWbT           wb,
    input  wire                  exMemStall,
    output exMemT                exMem,
    output logic                 redirect,
    output logic [dataWidth-1:0] redirectPc
);

    fwdSelE rs1Sel;
    fwdSelE rs2Sel;
    logic [dataWidth-1:0] memAluVal;
    logic [dataWidth-1:0] rs1Val;
    logic [dataWidth-1:0] rs2Val;
    logic [dataWidth-1:0] aluA;
    logic [dataWidth-1:0] aluB;
    logic [dataWidth-1:0] aluResult;
    exMemT exMemNext;

    function automatic fwdSelE pickSource(input logic [regAddrWidth-1:0] rs);
        if (rs == '0) return fwdNone;
        if (memStage.valid && memStage.weReg && memStage.rd == rs) begin
            return (memStage.wbSel == wbMem) ? fwdMemLoad : fwdMemAlu;
        end
        if (wb.valid && wb.weReg && wb.rd == rs) return fwdWb;
        return fwdNone;
    endfunction

    function automatic logic [dataWidth-1:0] forward(input fwdSelE sel,
                                                     input logic [dataWidth-1:0] regVal);
        case (sel)
            fwdMemAlu: return memAluVal;
            fwdMemLoad: return loadData;
            fwdWb: return wb.data;
            default: return regVal;
        endcase
    endfunction

    // **************************************************
    // operand forwarding
    // **************************************************
    always_comb begin
        // a jal in memory forwards its link value
        memAluVal = (memStage.wbSel == wbPcPlus4) ? memStage.pc + dataWidth'(4)
                                                  : memStage.aluResult;
        rs1Sel = pickSource(idEx.rs1);
        rs2Sel = pickSource(idEx.rs2);
        rs1Val = forward(rs1Sel, idEx.rs1Val);
        rs2Val = forward(rs2Sel, idEx.rs2Val);
    end

    assign aluA = (idEx.ctrl.aSel == aSelPc) ? idEx.pc : rs1Val;
    assign aluB = (idEx.ctrl.bSel == bSelImm) ? idEx.imm : rs2Val;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluSub: aluResult = aluA - aluB;
            aluAnd: aluResult = aluA & aluB;
            aluOr: aluResult = aluA | aluB;
            aluXor: aluResult = aluA ^ aluB;
            default: aluResult = aluA + aluB;
        endcase
    end

    // ctrl is cleared for bubbles, so only real instructions redirect
    assign redirect = idEx.ctrl.isJump
                      || (idEx.ctrl.isBranch && ((rs1Val == rs2Val) ^ idEx.ctrl.branchNe));
    assign redirectPc = aluResult;  // pc plus the immediate for branches and jal

    always_comb begin
        exMemNext.valid = idEx.valid;
        exMemNext.pc = idEx.pc;
        exMemNext.weReg = idEx.ctrl.weReg;
        exMemNext.weMem = idEx.ctrl.weMem;
        exMemNext.reMem = idEx.ctrl.reMem;
        exMemNext.wbSel = idEx.ctrl.wbSel;
        exMemNext.rd = idEx.rd;
        exMemNext.aluResult = aluResult;
        exMemNext.storeData = rs2Val;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exMem.valid <= 1'b0;
            exMem.weReg <= 1'b0;
            exMem.weMem <= 1'b0;
            exMem.reMem <= 1'b0;
        end else if (!exMemStall) begin
            exMem <= exMemNext;
        end
    end

    assert property (@(posedge clk) redirect |-> idEx.valid);

endmodule

`default_nettype wire

/* design/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage import corePkg::*; (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire [dataWidth-1:0]  idPc,
    input  wire [instWidth-1:0]  idInst,
    input  wire                  idValid,
    input  wire                  idExStall,
    input  wire                  idExFlush,
    input  wire memWbT           wb,
    output idExT                 idEx
);

    logic [dataWidth-1:0] regFile [1:31];  // x0 has no storage
    opcodeE opcode;
    ctrlT ctrl;
    logic known;
    logic wbWrite;
    logic [regAddrWidth-1:0] rs1;
    logic [regAddrWidth-1:0] rs2;
    logic [dataWidth-1:0] imm;
    idExT idExNext;

    assign opcode = opcodeE'(idInst[6:0]);
    assign rs1 = idInst[19:15];
    assign rs2 = idInst[24:20];
    assign wbWrite = wb.weReg && (wb.rd != '0);

    function automatic logic [dataWidth-1:0] readReg(input logic [regAddrWidth-1:0] idx);
        if (idx == '0) return '0;
        if (wbWrite && wb.rd == idx) return wb.data;  // same-cycle write wins
        return regFile[idx];
    endfunction

    // **************************************************
    // decoder and immediate
    // **************************************************
    always_comb begin
        ctrl = '0;
        known = 1'b1;
        imm = {{(dataWidth-12){idInst[31]}}, idInst[31:20]};
        case (opcode)
            opReg: begin
                ctrl.weReg = 1'b1;
                case (idInst[14:12])
                    3'b000: ctrl.aluOp = idInst[30] ? aluSub : aluAdd;
                    3'b100: ctrl.aluOp = aluXor;
                    3'b110: ctrl.aluOp = aluOr;
                    3'b111: ctrl.aluOp = aluAnd;
                    default: known = 1'b0;
                endcase
            end
            opImm: begin
                ctrl.weReg = 1'b1;
                ctrl.bSel = bSelImm;
                known = (idInst[14:12] == 3'b000);  // addi only
            end
            opLoad: begin
                ctrl.weReg = 1'b1;
                ctrl.reMem = 1'b1;
                ctrl.bSel = bSelImm;
                ctrl.wbSel = wbMem;
                known = (idInst[14:12] == 3'b011);
            end
            opStore: begin
                ctrl.weMem = 1'b1;
                ctrl.bSel = bSelImm;
                imm = {{(dataWidth-12){idInst[31]}}, idInst[31:25], idInst[11:7]};
                known = (idInst[14:12] == 3'b011);
            end
            opBranch: begin
                ctrl.isBranch = 1'b1;
                ctrl.branchNe = idInst[12];
                ctrl.aSel = aSelPc;  // the alu forms the branch target
                ctrl.bSel = bSelImm;
                imm = {{(dataWidth-12){idInst[31]}}, idInst[7], idInst[30:25],
                       idInst[11:8], 1'b0};
                known = (idInst[14:13] == 2'b00);
            end
            opJal: begin
                ctrl.isJump = 1'b1;
                ctrl.weReg = 1'b1;
                ctrl.aSel = aSelPc;
                ctrl.bSel = bSelImm;
                ctrl.wbSel = wbPcPlus4;
                imm = {{(dataWidth-20){idInst[31]}}, idInst[19:12], idInst[20],
                       idInst[30:21], 1'b0};
            end
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        idExNext.valid = idValid && known;
        idExNext.ctrl = idExNext.valid ? ctrl : '0;  // unknown words leave as bubbles
        idExNext.pc = idPc;
        idExNext.rs1 = rs1;
        idExNext.rs2 = rs2;
        idExNext.rd = idInst[11:7];
        idExNext.rs1Val = readReg(rs1);
        idExNext.rs2Val = readReg(rs2);
        idExNext.imm = imm;
    end

    always_ff @(posedge clk) begin
        if (wbWrite) begin
            regFile[wb.rd] <= wb.data;
        end
    end

    // **************************************************
    // ID/EX register
    // **************************************************
    always_ff @(posedge clk) begin
        if (!rstN || idExFlush) begin
            idEx.valid <= 1'b0;
            idEx.ctrl <= '0;
        end else if (idExStall) begin
            // writeback leaves during a stall and the held operands take its result
            if (wbWrite && wb.rd == idEx.rs1) begin
                idEx.rs1Val <= wb.data;
            end
            if (wbWrite && wb.rd == idEx.rs2) begin
                idEx.rs2Val <= wb.data;
            end
        end else begin
            idEx <= idExNext;
        end
    end

endmodule

`default_nettype wire

/* design/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage import corePkg::*; #(
    parameter logic [dataWidth-1:0] resetVector = '0
) (
    input  wire                   clk,
    input  wire                   rstN,
    input  wire                   pcStall,
    input  wire                   ifIdStall,
    input  wire                   ifIdFlush,
    input  wire                   redirect,
    input  wire  [dataWidth-1:0]  redirectPc,
    input  wire  [instWidth-1:0]  inst,
    output logic [dataWidth-1:0]  pc,
    output logic [dataWidth-1:0]  idPc,
    output logic [instWidth-1:0]  idInst,
    output logic                  idValid
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= resetVector;
        end else if (!pcStall) begin
            pc <= redirect ? redirectPc : pc + dataWidth'(4);  // redirect comes from execute
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || ifIdFlush) begin
            idValid <= 1'b0;
        end else if (!ifIdStall) begin
            idValid <= 1'b1;
            idPc <= pc;
            idInst <= inst;  // memory answers in the same cycle
        end
    end

    // execute is empty during reset, so no redirect can be taken then
    assert property (@(posedge clk) (!rstN && !pcStall) |-> !redirect);

endmodule

`default_nettype wire

/* design/corePkg.sv */
`default_nettype none

package corePkg;

    localparam int dataWidth = 64;
    localparam int regAddrWidth = 5;
    localparam int instWidth = 32;

    // **************************************************
    // encodings
    // **************************************************
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } opcodeE;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor} aluOpE;
    typedef enum logic {aSelReg, aSelPc} aSelE;
    typedef enum logic {bSelReg, bSelImm} bSelE;
    typedef enum logic [1:0] {wbAlu, wbMem, wbPcPlus4} wbSelE;
    typedef enum logic [1:0] {fwdNone, fwdMemAlu, fwdMemLoad, fwdWb} fwdSelE;

    // **************************************************
    // pipeline registers
    // **************************************************
    typedef struct packed {
        logic weReg;
        logic weMem;
        logic reMem;
        logic isBranch;
        logic isJump;
        logic branchNe;  // bne when set, beq otherwise
        aluOpE aluOp;
        aSelE aSel;
        bSelE bSel;
        wbSelE wbSel;
    } ctrlT;

    typedef struct packed {
        logic valid;
        logic [dataWidth-1:0] pc;
        ctrlT ctrl;
        logic [regAddrWidth-1:0] rs1;
        logic [regAddrWidth-1:0] rs2;
        logic [regAddrWidth-1:0] rd;
        logic [dataWidth-1:0] rs1Val;
        logic [dataWidth-1:0] rs2Val;
        logic [dataWidth-1:0] imm;
    } idExT;

    typedef struct packed {
        logic valid;
        logic [dataWidth-1:0] pc;  // kept for the link value of jal
        logic weReg;
        logic weMem;
        logic reMem;
        wbSelE wbSel;
        logic [regAddrWidth-1:0] rd;
        logic [dataWidth-1:0] aluResult;
        logic [dataWidth-1:0] storeData;
    } exMemT;

    typedef struct packed {
        logic valid;
        logic weReg;
        logic [regAddrWidth-1:0] rd;
        logic [dataWidth-1:0] data;
    } memWbT;

endpackage

`default_nettype wire
